//--- kcpu_config.svh
// **********************************************************
// global sizing macros for the microcoded core
// data width, microcode address split, divider length
// **********************************************************

`ifndef KCPU_CONFIG_SVH
`define KCPU_CONFIG_SVH

// accumulator and operand width
`define KCPU_DATA_W     8

// ucode address = {category, step}
`define KCPU_UCODE_AW   7
`define KCPU_OPCAT_AW   3
`define KCPU_STEP_W     4

// one quotient bit per iteration
`define KCPU_DIV_STEPS  8

`endif

//--- kcpu_pkg.sv
// **********************************************************
// shared types: opcodes, categories, alu commands
// microcode row, instruction word and result message
// **********************************************************

`default_nettype none

`include "kcpu_config.svh"

package kcpu_pkg;

    // instruction set, anything else is illegal
    typedef enum logic [7:0] {
        LDA_IMM  = 8'h86,
        LDB_IMM  = 8'hc6,
        ADDA_IMM = 8'h8b,
        ADDB_IMM = 8'hcb,
        SUBA_IMM = 8'h80,
        ANDA_IMM = 8'h84,
        LSRA     = 8'h44,
        DIVAB    = 8'h8e
    } opcode_e;

    // opcodes parsed by the same routine share a category
    typedef enum logic [`KCPU_OPCAT_AW-1:0] {
        FETCH      = 3'd0,
        LOAD       = 3'd1,
        SINGLE_ALU = 3'd2,
        ALU_MULTI  = 3'd3,
        BUSERROR   = 3'd4
    } opcat_e;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_LDA, ALU_LDB, ALU_ADDA, ALU_ADDB,
        ALU_SUBA, ALU_ANDA, ALU_LSRA, ALU_DIV
    } alu_op_e;

    typedef struct packed {
        logic    ni;          // dispatch on held opcode
        logic    pull_op;     // consume the held word
        logic    alu_start;
        alu_op_e alu_op;      // ALU_NOP -> command decoded from opcode
        logic    wait_busy;
        logic    push_result;
        logic    bus_error;   // halt row, err flag on push
    } ucode_t;

    typedef struct packed {
        opcode_e                 opcode;
        logic [`KCPU_DATA_W-1:0] operand;
    } op_word_t;

    typedef struct packed {
        opcode_e                 opcode;
        logic [`KCPU_DATA_W-1:0] a;
        logic [`KCPU_DATA_W-1:0] b;
        logic                    err;
    } result_t;

endpackage

`default_nettype wire

//--- kcpu_op_rx.sv
// **********************************************************
// four-phase instruction receiver
// one-entry holding register in front of the sequencer
// **********************************************************

`timescale 1ns/1ns
`default_nettype none

module kcpu_op_rx import kcpu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    // fetch unit side
    input  wire logic     op_req,
    input  wire op_word_t op_in,
    output logic          op_ack,
    // sequencer side
    output logic          op_valid,
    output op_word_t      op_held,
    input  wire logic     op_take
);

    logic full;     // holding register occupied
    logic capture;

    // new request, register free and previous ack already dropped
    assign capture = op_req && !op_ack && !full;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_ack <= 1'b0;
            full   <= 1'b0;
        end else begin
            if (capture) begin
                op_ack <= 1'b1;
                full   <= 1'b1;
            end else if (op_ack && !op_req) begin
                op_ack <= 1'b0;   // last phase, sender released req
            end
            if (op_take)
                full <= 1'b0;     // sequencer owns the word now
        end
    end

    // payload, only meaningful while full
    always_ff @(posedge clk) begin
        if (capture)
            op_held <= op_in;
    end

    assign op_valid = full;

    // sender must hold the word until it sees ack
    a_op_in_stable: assert property (@(posedge clk) disable iff (rst)
        op_req && !op_ack |=> $stable(op_in))
        else $error("op_in changed before op_ack");

endmodule

`default_nettype wire

//--- kcpu_ucode.sv
// **********************************************************
// microcode sequencer
// opcode -> category decode, constant row table,
// address stepping with busy / back-pressure stalls
// **********************************************************

`timescale 1ns/1ns
`default_nettype none

`include "kcpu_config.svh"

module kcpu_ucode import kcpu_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    op_valid,
    input  wire op_word_t                op_held,
    output logic                         op_take,
    output logic                         alu_start,
    output alu_op_e                      alu_cmd,
    output logic [`KCPU_DATA_W-1:0]      alu_operand,
    input  wire logic                    alu_busy,
    input  wire logic [`KCPU_DATA_W-1:0] acc_a,
    input  wire logic [`KCPU_DATA_W-1:0] acc_b,
    input  wire logic                    tx_ready,
    output logic                         res_load,
    output result_t                      res_data
);

    logic [`KCPU_UCODE_AW-1:0] addr;     // current row
    opcat_e                    addr_cat;
    logic [`KCPU_STEP_W-1:0]   addr_step;
    opcat_e                    held_cat; // category of waiting word
    op_word_t                  cur;      // instruction being executed
    alu_op_e                   cur_cmd;
    ucode_t                    row;
    logic                      stall, halt;

    assign addr_cat  = opcat_e'(addr[`KCPU_UCODE_AW-1:`KCPU_STEP_W]);
    assign addr_step = addr[`KCPU_STEP_W-1:0];

    always_comb begin
        case (op_held.opcode)
            LDA_IMM, LDB_IMM:                       held_cat = LOAD;
            ADDA_IMM, ADDB_IMM, SUBA_IMM, ANDA_IMM: held_cat = SINGLE_ALU;
            LSRA, DIVAB:                            held_cat = ALU_MULTI;
            default:                                held_cat = BUSERROR; // stop
        endcase
    end

    // alu command decoded from the executing opcode
    always_comb begin
        case (cur.opcode)
            LDA_IMM:  cur_cmd = ALU_LDA;
            LDB_IMM:  cur_cmd = ALU_LDB;
            ADDA_IMM: cur_cmd = ALU_ADDA;
            ADDB_IMM: cur_cmd = ALU_ADDB;
            SUBA_IMM: cur_cmd = ALU_SUBA;
            ANDA_IMM: cur_cmd = ALU_ANDA;
            LSRA:     cur_cmd = ALU_LSRA;
            DIVAB:    cur_cmd = ALU_DIV;
            default:  cur_cmd = ALU_NOP;
        endcase
    end

    // microcode table with 16 rows per category
    always_comb begin
        row = '0;
        case (addr_cat)
            FETCH: begin             // idles here until a word is held
                row.ni      = 1'b1;
                row.pull_op = 1'b1;
            end
            LOAD, SINGLE_ALU: begin
                if (addr_step == '0) begin
                    row.alu_start = 1'b1;
                end else begin       // report the updated acc and dispatch
                    row.push_result = 1'b1;
                    row.ni          = 1'b1;
                    row.pull_op     = 1'b1;
                end
            end
            ALU_MULTI: begin
                if (addr_step == '0) begin
                    row.alu_start = 1'b1;
                end else if (addr_step == `KCPU_STEP_W'(1)) begin
                    row.wait_busy = 1'b1;   // shift / divide iterations
                end else begin
                    row.push_result = 1'b1;
                    row.ni          = 1'b1;
                    row.pull_op     = 1'b1;
                end
            end
            BUSERROR: begin
                row.bus_error = 1'b1;
                if (addr_step == '0)
                    row.push_result = 1'b1; // one error message before the halt
            end
            default: row.bus_error = 1'b1; // unused categories also halt
        endcase
    end

    assign halt  = row.bus_error && !row.push_result;
    assign stall = (row.wait_busy && alu_busy) || (row.push_result && !tx_ready) || halt;

    assign op_take     = row.ni && row.pull_op && op_valid && !stall;
    assign alu_start   = row.alu_start;
    assign alu_cmd     = cur_cmd;
    assign alu_operand = cur.operand;
    assign res_load    = row.push_result && tx_ready;
    assign res_data    = '{opcode: cur.opcode, a: acc_a, b: acc_b, err: row.bus_error};

    always_ff @(posedge clk) begin
        if (rst) begin
            addr <= '0;                  // FETCH routine
        end else if (!stall) begin
            if (row.ni)
                addr <= op_take ? {held_cat, `KCPU_STEP_W'(0)} : '0;
            else
                addr <= addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (op_take)
            cur <= op_held;
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        alu_start |-> !alu_busy)
        else $error("alu_start while ALU busy");

    // the sender must turn busy so a second push cannot overwrite the message
    a_load_ready: assert property (@(posedge clk) disable iff (rst)
        res_load |=> !tx_ready)
        else $error("tx_ready still high after res_load");

endmodule

`default_nettype wire

//--- kcpu_alu.sv
// **********************************************************
// ALU with accumulators A and B
// single-cycle ops, iterative LSRA and restoring DIV
// **********************************************************

`timescale 1ns/1ns
`default_nettype none

`include "kcpu_config.svh"

module kcpu_alu import kcpu_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    alu_start,
    input  wire alu_op_e                 alu_cmd,
    input  wire logic [`KCPU_DATA_W-1:0] alu_operand,
    output logic                         alu_busy,
    output logic [`KCPU_DATA_W-1:0]      acc_a,
    output logic [`KCPU_DATA_W-1:0]      acc_b
);

    localparam int W       = `KCPU_DATA_W;
    localparam int CNT_W   = $clog2(`KCPU_DIV_STEPS + 1);
    localparam int SHIFT_W = $clog2(`KCPU_DATA_W);   // shift count = operand mod 8

    logic               div_mode;   // iterating DIV, else LSRA
    logic [CNT_W-1:0]   cnt;        // iterations left
    logic [W-1:0]       rem;        // partial remainder
    logic [W:0]         rem_sh;
    logic [W:0]         rem_diff;
    logic               fits;       // next quotient bit
    logic [W-1:0]       rem_next;
    logic [SHIFT_W-1:0] shift_cnt;

    assign shift_cnt = alu_operand[SHIFT_W-1:0];

    // restoring divide step, A shifts out the dividend and collects the quotient
    always_comb begin
        rem_sh   = {rem, acc_a[W-1]};
        rem_diff = rem_sh - {1'b0, acc_b};
        fits     = rem_sh >= {1'b0, acc_b};  // b == 0 always fits -> quotient 255
        rem_next = fits ? rem_diff[W-1:0] : rem_sh[W-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_a    <= '0;
            acc_b    <= '0;
            alu_busy <= 1'b0;
            div_mode <= 1'b0;
            cnt      <= '0;
        end else if (alu_busy) begin
            if (div_mode) begin
                acc_a <= {acc_a[W-2:0], fits};
                if (cnt == CNT_W'(1))
                    acc_b <= rem_next;   // remainder lands in B
            end else begin
                acc_a <= acc_a >> 1;
            end
            cnt <= cnt - 1'b1;
            if (cnt == CNT_W'(1))
                alu_busy <= 1'b0;
        end else if (alu_start) begin
            case (alu_cmd)
                ALU_LDA:  acc_a <= alu_operand;
                ALU_LDB:  acc_b <= alu_operand;
                ALU_ADDA: acc_a <= acc_a + alu_operand;   // wraps mod 256
                ALU_ADDB: acc_b <= acc_b + alu_operand;
                ALU_SUBA: acc_a <= acc_a - alu_operand;
                ALU_ANDA: acc_a <= acc_a & alu_operand;
                ALU_LSRA: begin
                    if (shift_cnt != '0) begin   // zero count finishes at once
                        alu_busy <= 1'b1;
                        div_mode <= 1'b0;
                        cnt      <= CNT_W'(shift_cnt);
                    end
                end
                ALU_DIV: begin
                    alu_busy <= 1'b1;
                    div_mode <= 1'b1;
                    cnt      <= CNT_W'(`KCPU_DIV_STEPS);
                end
                default: ;  // ALU_NOP
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start && alu_cmd == ALU_DIV && !alu_busy)
            rem <= '0;
        else if (alu_busy && div_mode)
            rem <= rem_next;
    end

endmodule

`default_nettype wire

//--- kcpu_result_tx.sv
// **********************************************************
// four-phase sender for result messages
// holds one result until the consumer releases ack
// **********************************************************

`timescale 1ns/1ns
`default_nettype none

module kcpu_result_tx import kcpu_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    res_load,
    input  wire result_t res_data,
    output logic         tx_ready,
    output logic         res_req,
    output result_t      res_out,
    input  wire logic    res_ack
);

    typedef enum logic [1:0] {IDLE, REQ, WAIT_ACK_LOW} tx_state_e;

    tx_state_e state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:         if (res_load) state <= REQ;
                REQ:          if (res_ack) state <= WAIT_ACK_LOW;  // drop req
                WAIT_ACK_LOW: if (!res_ack) state <= IDLE;
                default:      state <= IDLE;
            endcase
        end
    end

    // message register written by res_load
    always_ff @(posedge clk) begin
        if (res_load)
            res_out <= res_data;
    end

    assign res_req  = (state == REQ);
    assign tx_ready = (state == IDLE);

    a_res_out_stable: assert property (@(posedge clk) disable iff (rst)
        res_req |=> !res_req || $stable(res_out))
        else $error("res_out changed while res_req high");

endmodule

`default_nettype wire

//--- kcpu_top.sv
// **********************************************************
// core top level
// receiver, microcode sequencer, ALU and result sender
// **********************************************************

`timescale 1ns/1ns
`default_nettype none

`include "kcpu_config.svh"

module kcpu_top import kcpu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     op_req,
    input  wire op_word_t op_in,
    output logic          op_ack,
    output logic          res_req,
    output result_t       res_out,
    input  wire logic     res_ack
);

    logic                    op_valid, op_take;
    op_word_t                op_held;
    logic                    alu_start, alu_busy;
    alu_op_e                 alu_cmd;
    logic [`KCPU_DATA_W-1:0] alu_operand, acc_a, acc_b;
    logic                    tx_ready, res_load;
    result_t                 res_data;

    kcpu_op_rx rx_i (
        .clk, .rst, .op_req, .op_in, .op_ack,
        .op_valid, .op_held, .op_take
    );

    kcpu_ucode ucode_i (
        .clk, .rst, .op_valid, .op_held, .op_take,
        .alu_start, .alu_cmd, .alu_operand, .alu_busy, .acc_a, .acc_b,
        .tx_ready, .res_load, .res_data
    );

    kcpu_alu alu_i (
        .clk, .rst, .alu_start, .alu_cmd, .alu_operand,
        .alu_busy, .acc_a, .acc_b
    );

    kcpu_result_tx tx_i (
        .clk, .rst, .res_load, .res_data, .tx_ready,
        .res_req, .res_out, .res_ack
    );

endmodule

`default_nettype wire

//--- tb_kcpu.sv
// **********************************************************
// testbench for the microcoded core
// trace-driven op sender, random-delay result acknowledge
// **********************************************************

`timescale 1ns/1ns
`default_nettype none

module tb_kcpu import kcpu_pkg::*; ();

    logic     clk;
    logic     rst;
    logic     op_req, op_ack;
    op_word_t op_in;
    logic     res_req, res_ack;
    result_t  res_out;

    // trace columns are opcode, operand and expected A, B, err
    logic [7:0] tr_op[$];
    logic [7:0] tr_arg[$];
    logic [7:0] tr_a[$];
    logic [7:0] tr_b[$];
    logic [7:0] tr_err[$];

    int errors;
    int tests_run;
    int tests_failed;
    bit abort;      // set when a handshake gets stuck so both processes stop

    kcpu_top dut_i (
        .clk, .rst, .op_req, .op_in, .op_ack,
        .res_req, .res_out, .res_ack
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // drive and sample point 2 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input logic [7:0] got, input logic [7:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wait_op_ack(input logic level, output bit ok);
        int n;
        n = 0;
        while (op_ack !== level && n < 200) begin
            tick();
            n++;
        end
        ok = (op_ack === level);
        if (!ok) begin
            $display("timeout: op_ack did not go to %b within 200 cycles", level);
            errors++;
        end
    endtask

    // with quiet set an expiry is expected and not reported
    task automatic wait_res_req(input logic level, input int limit, input bit quiet,
                                output bit ok);
        int n;
        n = 0;
        while (res_req !== level && n < limit) begin
            tick();
            n++;
        end
        ok = (res_req === level);
        if (!ok && !quiet) begin
            $display("timeout: res_req did not go to %b within %0d cycles", level, limit);
            errors++;
        end
    endtask

    task automatic load_trace();
        int         fd, cnt;
        string      line;
        logic [7:0] f_op, f_arg, f_a, f_b, f_err;
        fd = $fopen("kcpu_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file kcpu_trace.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            cnt  = $fgets(line, fd);
            if (cnt > 0 && line[0] != "#") begin   // skip column notes
                cnt = $sscanf(line, "%h %h %h %h %h", f_op, f_arg, f_a, f_b, f_err);
                if (cnt == 5) begin
                    tr_op.push_back(f_op);
                    tr_arg.push_back(f_arg);
                    tr_a.push_back(f_a);
                    tr_b.push_back(f_b);
                    tr_err.push_back(f_err);
                end
            end
        end
        $fclose(fd);
        if (tr_op.size() == 0) begin
            $display("trace file holds no instruction lines");
            errors++;
        end
    endtask

    // four-phase sender with one word per trace line
    task automatic send_ops();
        bit ok;
        for (int i = 0; i < tr_op.size() && !abort; i++) begin
            op_in.opcode  = opcode_e'(tr_op[i]);   // illegal values pass through too
            op_in.operand = tr_arg[i];
            op_req        = 1'b1;
            wait_op_ack(1'b1, ok);
            if (!ok) begin
                abort = 1'b1;
            end else begin
                op_req = 1'b0;
                wait_op_ack(1'b0, ok);
                if (!ok)
                    abort = 1'b1;
            end
        end
        op_req = 1'b0;
    endtask

    // random ack delay on the result side gives back-pressure
    task automatic receive_results();
        bit ok;
        bit halted;     // no more messages allowed after a bus error
        int delay;
        int err_before;
        halted = 1'b0;
        for (int i = 0; i < tr_op.size() && !abort; i++) begin
            err_before = errors;
            tests_run++;
            if (halted) begin
                wait_res_req(1'b1, 200, 1'b1, ok);   // expected to expire
                if (ok) begin
                    $display("[ERROR] %0t ns: result message after bus error halt", $time);
                    errors++;
                end
            end else begin
                wait_res_req(1'b1, 200, 1'b0, ok);
                if (!ok) begin
                    abort = 1'b1;
                end else begin
                    check_value(res_out.opcode, tr_op[i], "opcode");
                    check_value(res_out.a, tr_a[i], "acc A");
                    check_value(res_out.b, tr_b[i], "acc B");
                    check_value({7'b0, res_out.err}, tr_err[i], "err flag");
                    halted = (tr_err[i] != 8'h00);
                    delay  = $urandom % 6;
                    repeat (delay) tick();
                    res_ack = 1'b1;
                    wait_res_req(1'b0, 200, 1'b0, ok);
                    res_ack = 1'b0;
                    if (!ok)
                        abort = 1'b1;
                end
            end
            if (errors == err_before) begin
                $display("test %0d op %02h: ok%s", i + 1, tr_op[i],
                         halted && tr_err[i] == 8'h00 ? " (no result, core halted)" : "");
            end else begin
                $display("test %0d op %02h: mismatch", i + 1, tr_op[i]);
                tests_failed++;
            end
        end
    endtask

    initial begin
        void'($urandom(63));
        rst          = 1'b1;
        op_req       = 1'b0;
        op_in        = '0;
        res_ack      = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        abort        = 1'b0;
        load_trace();
        repeat (4) tick();       // reset for 4 cycles
        rst = 1'b0;
        tick();
        fork
            send_ops();
            receive_results();
        join
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !abort)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- kcpu_trace.txt
# opcode operand exp_a exp_b exp_err, all hex, one instruction per line
# a line after an err line expects op_ack but no result message
86 5a 5a 00 0
c6 03 5a 03 0
8b 20 7a 03 0
8b f0 6a 03 0
cb fe 6a 01 0
80 70 fa 01 0
84 3c 38 01 0
86 c8 c8 01 0
44 00 c8 01 0
44 03 19 01 0
86 f1 f1 01 0
44 0f 01 01 0
86 c8 c8 01 0
c6 07 c8 07 0
8e 00 1c 04 0
86 64 64 04 0
c6 00 64 00 0
8e 00 ff 64 0
8e 00 02 37 0
3f 11 02 37 1
86 99 02 37 0

//--- src.f
+incdir+.
kcpu_pkg.sv
kcpu_op_rx.sv
kcpu_ucode.sv
kcpu_alu.sv
kcpu_result_tx.sv
kcpu_top.sv
tb_kcpu.sv

//--- Bender.yml
package:
  name: kcpu

export_include_dirs:
  - .

sources:
  - kcpu_pkg.sv
  - kcpu_op_rx.sv
  - kcpu_ucode.sv
  - kcpu_alu.sv
  - kcpu_result_tx.sv
  - kcpu_top.sv
  - target: test
    files:
      - tb_kcpu.sv
